//--- include/vram_macros.svh
`ifndef VRAM_MACROS_SVH
`define VRAM_MACROS_SVH

// ***************************************************************************
// Memory geometry
// ***************************************************************************

// Rows per RAM block
`define VRAM_ROWS 16384

// Pixels packed into one 16-bit halfword
`define PIX_PER_HALF 4

// ***************************************************************************
// Video timing, shortened for simulation
// ***************************************************************************

`define H_ACTIVE 16
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 3

`define V_ACTIVE 8
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1

`endif

//--- logic/vram_pkg.sv
package vram_pkg;

    // Bus side
    // bit 14 picks the bank pair, 13..0 the row
    typedef logic [14:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0] wb_sel_t;

    // Video side
    // bit 15 pair, 14..1 row, bit 0 half
    typedef logic [15:0] vid_addr_t;

    // RAM block
    typedef logic [15:0] half_t;
    typedef logic [13:0] ram_addr_t;
    typedef logic [3:0] nib_mask_t;

    // One pixel index
    typedef logic [3:0] pix_t;

    // Halfword fetch sequencing in the scan-out engine
    typedef enum logic [1:0] {
        scan_idle,
        scan_fetch,
        scan_capture
    } scan_state_t;

endpackage

//--- logic/spram_bank.sv
`timescale 1ns/1ps

`include "vram_macros.svh"

module spram_bank
    import vram_pkg::*;
(
    input  logic      I_wb_clk,
    input  ram_addr_t addr,
    input  half_t     din,
    input  nib_mask_t mask,
    input  logic      we,
    input  logic      cs,
    output half_t     dout
);

    localparam int NIB_W = $bits(half_t) / $bits(nib_mask_t);

    half_t mem [`VRAM_ROWS];

    // Single port, one access per selected edge
    always_ff @(posedge I_wb_clk) begin
        if (cs) begin
            if (we) begin
                for (int n = 0; n < $bits(nib_mask_t); n++) begin
                    if (mask[n]) begin
                        mem[addr][n*NIB_W +: NIB_W] <= din[n*NIB_W +: NIB_W];
                    end
                end
            end else begin
                // Output only refreshes on a read
                dout <= mem[addr];
            end
        end
    end

endmodule

//--- logic/vram_spram_wb32.sv
`timescale 1ns/1ps

module vram_spram_wb32
    import vram_pkg::*;
(
    input  logic      I_wb_clk,
    input  logic      arst_n,

    input  logic      wb_stb,
    input  logic      wb_we,
    input  wb_addr_t  wb_adr,
    input  wb_sel_t   wb_sel,
    input  wb_data_t  wb_dat,
    output wb_data_t  wb_dat_o,
    output logic      wb_ack,
    output logic      wb_stall,

    input  logic      vid_req,
    input  vid_addr_t vid_adr,
    output half_t     vid_dat
);

    localparam int PAIR_BIT = $bits(wb_addr_t) - 1;
    localparam int HW = $bits(half_t);

    half_t      rd00;
    half_t      rd01;
    half_t      rd10;
    half_t      rd11;
    ram_addr_t  ram_adr;
    logic       ram_cs;
    logic       ram_we;
    wb_sel_t    sel0;
    wb_sel_t    sel1;
    nib_mask_t  mask00;
    nib_mask_t  mask01;
    nib_mask_t  mask10;
    nib_mask_t  mask11;
    logic       bus_pair_q;
    logic [1:0] vid_sel_q;

    // Each byte lane covers two nibbles
    function automatic nib_mask_t lanes_to_nibs(input logic [1:0] lanes);
        return {{2{lanes[1]}}, {2{lanes[0]}}};
    endfunction

    // ***********************************************************************
    // Arbitration, video wins
    // ***********************************************************************

    assign wb_stall = wb_stb & vid_req;
    assign ram_we = wb_stb & wb_we & ~vid_req;
    assign ram_cs = wb_stb | vid_req;
    assign ram_adr = vid_req ? vid_adr[14:1] : wb_adr[13:0];

    // Lane selects only reach the addressed pair
    assign sel0 = wb_adr[PAIR_BIT] ? '0 : wb_sel;
    assign sel1 = wb_adr[PAIR_BIT] ? wb_sel : '0;

    assign mask00 = lanes_to_nibs(sel0[1:0]);
    assign mask01 = lanes_to_nibs(sel0[3:2]);
    assign mask10 = lanes_to_nibs(sel1[1:0]);
    assign mask11 = lanes_to_nibs(sel1[3:2]);

    spram_bank ram00 (
        .I_wb_clk (I_wb_clk),
        .addr     (ram_adr),
        .din      (wb_dat[HW-1:0]),
        .mask     (mask00),
        .we       (ram_we),
        .cs       (ram_cs),
        .dout     (rd00)
    );

    spram_bank ram01 (
        .I_wb_clk (I_wb_clk),
        .addr     (ram_adr),
        .din      (wb_dat[2*HW-1:HW]),
        .mask     (mask01),
        .we       (ram_we),
        .cs       (ram_cs),
        .dout     (rd01)
    );

    spram_bank ram10 (
        .I_wb_clk (I_wb_clk),
        .addr     (ram_adr),
        .din      (wb_dat[HW-1:0]),
        .mask     (mask10),
        .we       (ram_we),
        .cs       (ram_cs),
        .dout     (rd10)
    );

    spram_bank ram11 (
        .I_wb_clk (I_wb_clk),
        .addr     (ram_adr),
        .din      (wb_dat[2*HW-1:HW]),
        .mask     (mask11),
        .we       (ram_we),
        .cs       (ram_cs),
        .dout     (rd11)
    );

    // ***********************************************************************
    // Response side
    // ***********************************************************************

    // Pair and half bits kept from the access edge
    always_ff @(posedge I_wb_clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
            bus_pair_q <= 1'b0;
            vid_sel_q <= 2'b00;
        end else begin
            wb_ack <= wb_stb & ~wb_stall;
            bus_pair_q <= wb_adr[PAIR_BIT];
            if (vid_req) begin
                vid_sel_q <= {vid_adr[15], vid_adr[0]};
            end
        end
    end

    // Read buffer, half a cycle after the RAM edge
    always_ff @(negedge I_wb_clk) begin
        wb_dat_o <= bus_pair_q ? {rd11, rd10} : {rd01, rd00};
    end

    always_comb begin
        case (vid_sel_q)
            2'b00:   vid_dat = rd00;
            2'b01:   vid_dat = rd01;
            2'b10:   vid_dat = rd10;
            default: vid_dat = rd11;
        endcase
    end

endmodule

//--- logic/vga_scanout.sv
`timescale 1ns/1ps

`include "vram_macros.svh"

module vga_scanout
    import vram_pkg::*;
(
    input  logic      I_wb_clk,
    input  logic      arst_n,
    output logic      vid_req,
    output vid_addr_t vid_adr,
    input  half_t     vid_dat,
    output logic      hsync,
    output logic      vsync,
    output logic      de,
    output pix_t      pixel
);

    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int HS_START = `H_ACTIVE + `H_FRONT;
    localparam int HS_END = HS_START + `H_SYNC;
    localparam int VS_START = `V_ACTIVE + `V_FRONT;
    localparam int VS_END = VS_START + `V_SYNC;
    // Fetch is started this many pixels ahead of its group
    localparam int LEAD = 3;
    localparam int H_W = $clog2(H_TOTAL + LEAD);
    localparam int V_W = $clog2(V_TOTAL);
    localparam int LINE_HALVES = `H_ACTIVE / `PIX_PER_HALF;
    localparam int NIB_W = $clog2(`PIX_PER_HALF);
    localparam int PIX_W = $bits(pix_t);

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic [H_W-1:0] h_lead;
    logic [V_W-1:0] v_next;
    logic           line_end;
    logic           active;
    logic           fetch_now;
    logic [V_W-1:0] tgt_line;
    logic [H_W-1:0] tgt_group;
    vid_addr_t      tgt_adr;
    vid_addr_t      fetch_adr;
    scan_state_t    state;
    half_t          next_half;
    half_t          shreg;

    // ***********************************************************************
    // Position decode and fetch target
    // ***********************************************************************

    always_comb begin
        line_end = (h_cnt == H_W'(H_TOTAL - 1));
        v_next = (v_cnt == V_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        h_lead = h_cnt + H_W'(LEAD);
        active = (h_cnt < H_W'(`H_ACTIVE)) && (v_cnt < V_W'(`V_ACTIVE));

        if (h_lead == H_W'(H_TOTAL)) begin
            // First group of the coming line, issued in back porch
            tgt_line = v_next;
            tgt_group = '0;
            fetch_now = (v_next < V_W'(`V_ACTIVE));
        end else begin
            tgt_line = v_cnt;
            tgt_group = h_lead >> NIB_W;
            fetch_now = (h_lead[NIB_W-1:0] == '0) && (h_lead < H_W'(`H_ACTIVE))
                && (v_cnt < V_W'(`V_ACTIVE));
        end

        tgt_adr = vid_addr_t'(tgt_line) * vid_addr_t'(LINE_HALVES)
            + vid_addr_t'(tgt_group);
    end

    assign vid_req = (state == scan_fetch);
    assign vid_adr = fetch_adr;

    // ***********************************************************************
    // Counters, sync outputs and fetch FSM
    // ***********************************************************************

    always_ff @(posedge I_wb_clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
            state <= scan_idle;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de <= 1'b0;
            pixel <= '0;
        end else begin
            if (line_end) begin
                h_cnt <= '0;
                v_cnt <= v_next;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end

            // Active-low syncs
            hsync <= !((h_cnt >= H_W'(HS_START)) && (h_cnt < H_W'(HS_END)));
            vsync <= !((v_cnt >= V_W'(VS_START)) && (v_cnt < V_W'(VS_END)));
            de <= active;

            if (!active) begin
                pixel <= '0;
            end else if (h_cnt[NIB_W-1:0] == '0) begin
                pixel <= next_half[PIX_W-1:0];
            end else begin
                pixel <= shreg[PIX_W-1:0];
            end

            case (state)
                scan_idle: begin
                    if (fetch_now) begin
                        state <= scan_fetch;
                    end
                end
                scan_fetch: state <= scan_capture;
                default: state <= scan_idle;
            endcase
        end
    end

    // Halfword buffer and pixel shifter
    always_ff @(posedge I_wb_clk) begin
        if (state == scan_idle && fetch_now) begin
            fetch_adr <= tgt_adr;
        end
        if (state == scan_capture) begin
            next_half <= vid_dat;
        end
        if (h_cnt[NIB_W-1:0] == '0) begin
            shreg <= next_half >> PIX_W;
        end else begin
            shreg <= shreg >> PIX_W;
        end
    end

endmodule

//--- logic/vram_top.sv
`timescale 1ns/1ps

module vram_top
    import vram_pkg::*;
(
    input  logic     I_wb_clk,
    input  logic     arst_n,

    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_sel_t  wb_sel,
    input  wb_data_t wb_dat,
    output wb_data_t wb_dat_o,
    output logic     wb_ack,
    output logic     wb_stall,

    output logic     hsync,
    output logic     vsync,
    output logic     de,
    output pix_t     pixel
);

    // Video fetch path between scan-out and arbiter
    logic      vid_req;
    vid_addr_t vid_adr;
    half_t     vid_dat;

    vram_spram_wb32 mem_i (
        .I_wb_clk (I_wb_clk),
        .arst_n   (arst_n),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_dat   (wb_dat),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .wb_stall (wb_stall),
        .vid_req  (vid_req),
        .vid_adr  (vid_adr),
        .vid_dat  (vid_dat)
    );

    vga_scanout scan_i (
        .I_wb_clk (I_wb_clk),
        .arst_n   (arst_n),
        .vid_req  (vid_req),
        .vid_adr  (vid_adr),
        .vid_dat  (vid_dat),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .pixel    (pixel)
    );

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic I_wb_clk,
    output logic arst_n
);

    initial begin
        I_wb_clk = 1'b0;
        forever #HALF_PERIOD I_wb_clk = ~I_wb_clk;
    end

    // Released on a rising edge, so the first free-running edge is the next one
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge I_wb_clk);
        arst_n <= 1'b1;
    end

endmodule

//--- tests/vram_asserts.sv
`timescale 1ns/1ps

module vram_asserts (
    input logic I_wb_clk,
    input logic arst_n,
    input logic wb_stb,
    input logic wb_stall,
    input logic wb_ack
);

    // ************************************************************************
    // Bus handshake
    // ************************************************************************

    property ack_after_accept;
        @(posedge I_wb_clk) disable iff (!arst_n)
            (wb_stb && !wb_stall) |=> wb_ack;
    endproperty

    property ack_has_request;
        @(posedge I_wb_clk) disable iff (!arst_n)
            wb_ack |-> $past(wb_stb && !wb_stall);
    endproperty

    property stall_needs_stb;
        @(posedge I_wb_clk) disable iff (!arst_n)
            wb_stall |-> wb_stb;
    endproperty

    ack_after_accept_a: assert property (ack_after_accept)
        else $error("wb_ack missing one cycle after an accepted request");
    ack_has_request_a: assert property (ack_has_request)
        else $error("wb_ack without an accepted request one cycle earlier");
    stall_needs_stb_a: assert property (stall_needs_stb)
        else $error("wb_stall high while wb_stb is low");

endmodule

bind vram_top vram_asserts asserts_i (
    .I_wb_clk (I_wb_clk),
    .arst_n   (arst_n),
    .wb_stb   (wb_stb),
    .wb_stall (wb_stall),
    .wb_ack   (wb_ack)
);

//--- tests/vram_tb.sv
`timescale 1ns/1ps

`include "vram_macros.svh"

module vram_tb
    import vram_pkg::*;
();

    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int FRAME_WORDS = `V_ACTIVE * `H_ACTIVE / `PIX_PER_HALF / 2;
    localparam int N_WORDS = 24;
    localparam int WAIT_LIMIT = 64;

    logic     I_wb_clk;
    logic     arst_n;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_sel_t  wb_sel;
    wb_data_t wb_dat;
    wb_data_t wb_dat_o;
    logic     wb_ack;
    logic     wb_stall;
    logic     hsync;
    logic     vsync;
    logic     de;
    pix_t     pixel;

    logic [31:0] rng_state = 32'd2;
    wb_data_t    ref_mem [wb_addr_t];
    wb_addr_t    used_q [$];
    // {is_read, expected data}
    logic [32:0] exp_q [$];
    int          accepted = 0;
    int          acked = 0;
    int          stall_count = 0;

    clock_gen clk_i (.I_wb_clk(I_wb_clk), .arst_n(arst_n));

    vram_top dut_i (
        .I_wb_clk (I_wb_clk), .arst_n (arst_n),
        .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr), .wb_sel (wb_sel),
        .wb_dat (wb_dat), .wb_dat_o (wb_dat_o), .wb_ack (wb_ack), .wb_stall (wb_stall),
        .hsync (hsync), .vsync (vsync), .de (de), .pixel (pixel)
    );

    // ************************************************************************
    // Random numbers and reference model
    // ************************************************************************

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic logic [15:0] rand16();
        logic [31:0] s;
        s = lcg_next();
        return s[31:16];
    endfunction

    function automatic wb_data_t rand_word();
        return {rand16(), rand16()};
    endfunction

    function automatic void ref_write(input wb_addr_t adr, input wb_sel_t sel,
                                      input wb_data_t dat);
        wb_data_t word;
        word = ref_mem.exists(adr) ? ref_mem[adr] : 'x;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                word[b*8 +: 8] = dat[b*8 +: 8];
            end
        end
        ref_mem[adr] = word;
    endfunction

    function automatic wb_data_t ref_read(input wb_addr_t adr);
        return ref_mem.exists(adr) ? ref_mem[adr] : 'x;
    endfunction

    // Bus word w holds halfwords 2w (low) and 2w+1 (high)
    function automatic pix_t ref_pixel(input int x, input int y);
        int       h;
        wb_data_t word;
        half_t    half;
        h = y * (`H_ACTIVE / `PIX_PER_HALF) + x / `PIX_PER_HALF;
        word = ref_read(wb_addr_t'(h / 2));
        half = (h % 2 == 1) ? word[31:16] : word[15:0];
        return half[(x % `PIX_PER_HALF) * 4 +: 4];
    endfunction

    // ************************************************************************
    // Helpers
    // ************************************************************************

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    // Three quarters into the cycle and past the falling-edge read buffer
    task automatic wait_sample_point();
        @(posedge I_wb_clk);
        #15;
    endtask

    task automatic bus_request(input logic we, input wb_addr_t adr, input wb_sel_t sel,
                               input wb_data_t dat);
        int waited;
        @(posedge I_wb_clk);
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_sel <= sel;
        wb_dat <= dat;
        #5;
        waited = 0;
        while (wb_stall) begin
            stall_count++;
            waited++;
            assert (waited < 8) else fail_run($sformatf("Error at %0t: request stalled too long",
                                                         $time));
            wait_sample_point();
        end
        // Accepted at the coming edge
        accepted++;
        if (we) begin
            ref_write(adr, sel, dat);
        end
        exp_q.push_back({!we, ref_read(adr)});
    endtask

    task automatic bus_idle();
        @(posedge I_wb_clk);
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            wait_sample_point();
            waited++;
            assert (waited < WAIT_LIMIT)
                else fail_run($sformatf("Error at %0t: acks never arrived", $time));
        end
    endtask

    task automatic read_back_all();
        for (int i = 0; i < used_q.size(); i++) begin
            bus_request(1'b0, used_q[i], '0, '0);
        end
        bus_idle();
        wait_drain();
    endtask

    task automatic check_reset_state();
        assert (wb_ack === 1'b0 && hsync === 1'b1 && vsync === 1'b1 && de === 1'b0)
            else fail_run($sformatf("Mismatch at %0t: ack %b hsync %b vsync %b de %b in reset",
                                    $time, wb_ack, hsync, vsync, de));
    endtask

    task automatic wait_vsync(input logic level);
        int waited;
        waited = 0;
        while (vsync !== level) begin
            wait_sample_point();
            waited++;
            assert (waited <= FRAME_CYCLES)
                else fail_run($sformatf("Error at %0t: vsync stuck away from %b", $time, level));
        end
    endtask

    // One full frame from vsync rise to vsync rise
    task automatic check_video();
        int   cyc;
        int   hs_fall;
        int   vs_fall;
        int   x;
        int   y;
        logic prev_hs;
        logic prev_vs;
        logic prev_de;
        logic done;
        wait_vsync(1'b0);
        wait_vsync(1'b1);
        cyc = 0;
        hs_fall = -1;
        vs_fall = -1;
        x = 0;
        y = 0;
        prev_hs = hsync;
        prev_vs = vsync;
        prev_de = de;
        done = 1'b0;
        while (!done) begin
            wait_sample_point();
            cyc++;
            assert (cyc <= 2 * FRAME_CYCLES)
                else fail_run($sformatf("Error at %0t: frame never ended", $time));
            if (de) begin
                assert (pixel === ref_pixel(x, y))
                    else fail_run($sformatf("Mismatch at %0t: pixel (%0d,%0d) is %h, expected %h",
                                            $time, x, y, pixel, ref_pixel(x, y)));
                x++;
            end else if (prev_de) begin
                assert (x == `H_ACTIVE)
                    else fail_run($sformatf("Mismatch at %0t: %0d de cycles in line", $time, x));
                x = 0;
                y++;
            end
            if (!hsync && prev_hs) begin
                assert (hs_fall < 0 || cyc - hs_fall == H_TOTAL)
                    else fail_run($sformatf("Mismatch at %0t: hsync period %0d",
                                            $time, cyc - hs_fall));
                hs_fall = cyc;
            end
            if (hsync && !prev_hs && hs_fall >= 0) begin
                assert (cyc - hs_fall == `H_SYNC)
                    else fail_run($sformatf("Mismatch at %0t: hsync low for %0d cycles",
                                            $time, cyc - hs_fall));
            end
            if (!vsync && prev_vs) begin
                vs_fall = cyc;
            end
            if (vsync && !prev_vs) begin
                assert (cyc - vs_fall == `V_SYNC * H_TOTAL && cyc == FRAME_CYCLES)
                    else fail_run($sformatf("Mismatch at %0t: vsync low %0d, period %0d",
                                            $time, cyc - vs_fall, cyc));
                done = 1'b1;
            end
            prev_hs = hsync;
            prev_vs = vsync;
            prev_de = de;
        end
        assert (y == `V_ACTIVE)
            else fail_run($sformatf("Mismatch at %0t: %0d active lines in frame", $time, y));
    endtask

    // ************************************************************************
    // Ack checker
    // ************************************************************************

    initial begin : ack_checker
        logic [32:0] exp;
        forever begin
            wait_sample_point();
            if (wb_ack === 1'b1) begin
                assert (exp_q.size() > 0)
                    else fail_run($sformatf("Error at %0t: ack with no request pending", $time));
                exp = exp_q.pop_front();
                acked++;
                if (exp[32]) begin
                    assert (wb_dat_o === exp[31:0])
                        else fail_run($sformatf("Mismatch at %0t: read %h, expected %h",
                                                $time, wb_dat_o, exp[31:0]));
                end
            end
        end
    end

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    initial begin : stimulus
        wb_addr_t adr;
        int       waited;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_sel = '0;
        wb_dat = '0;

        waited = 0;
        do begin
            wait_sample_point();
            check_reset_state();
            waited++;
            assert (waited < 20) else fail_run($sformatf("Error at %0t: reset never released",
                                                         $time));
        end while (!arst_n);

        // Full words over alternating bank pairs
        for (int i = 0; i < N_WORDS; i++) begin
            adr = wb_addr_t'(rand16());
            adr[14] = i[0];
            used_q.push_back(adr);
            bus_request(1'b1, adr, 4'hF, rand_word());
        end
        read_back_all();

        // Byte-lane writes over known words
        for (int i = 0; i < N_WORDS; i++) begin
            adr = used_q[rand16() % used_q.size()];
            bus_request(1'b1, adr, wb_sel_t'(rand16() >> 3), rand_word());
        end
        read_back_all();

        // Tight write/read pairs run into video fetches
        for (int i = 0; i < 2 * N_WORDS; i++) begin
            bus_request(1'b1, used_q[0], 4'hF, rand_word());
            bus_request(1'b0, used_q[0], '0, '0);
        end
        bus_idle();
        wait_drain();

        // Frame area for scan-out
        for (int w = 0; w < FRAME_WORDS; w++) begin
            bus_request(1'b1, wb_addr_t'(w), 4'hF, rand_word());
        end
        bus_idle();
        wait_drain();
        check_video();

        if (acked == accepted && exp_q.size() == 0 && stall_count > 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Error at %0t: %0d accepted, %0d acked, %0d stalled cycles",
                     $time, accepted, acked, stall_count);
            $display("Something failed");
            $fatal(1, "bus transaction counts do not agree");
        end
    end

endmodule

//--- vram.f
+incdir+include
logic/vram_pkg.sv
logic/spram_bank.sv
logic/vram_spram_wb32.sv
logic/vga_scanout.sv
logic/vram_top.sv
tests/clock_gen.sv
tests/vram_asserts.sv
tests/vram_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the vram testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vram.f --top-module vram_tb -Mdir "$BUILD_DIR" -o vram_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/vram_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Simulation PASSED"
exit 0
